// ==== verilog/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // Device-type nibble that the EEPROM answers to
    localparam logic [3:0] dev_type = 4'b1010;

    localparam int mem_depth = 2048;
    localparam int addr_bits = 11;

    // System clocks per half period of the bus clock
    localparam int scl_half = 4;

    // APB byte offsets
    localparam logic [4:0] reg_ctrl   = 5'h00;
    localparam logic [4:0] reg_addr   = 5'h04;
    localparam logic [4:0] reg_wdata  = 5'h08;
    localparam logic [4:0] reg_status = 5'h0C;
    localparam logic [4:0] reg_rdata  = 5'h10;

    typedef enum logic {
        op_write,
        op_read
    } i2c_op_t;

    typedef enum logic [2:0] {
        e_idle,
        e_start,
        e_send_byte,
        e_get_ack,
        e_restart,
        e_recv_byte,
        e_send_nack,
        e_stop
    } eng_state_t;

    typedef enum logic [2:0] {
        s_idle,
        s_ctrl,
        s_addr,
        s_wdata,
        s_rdata,
        s_ack,
        s_ignore
    } slv_state_t;

endpackage

`default_nettype wire

// ==== verilog/i2c_cmd_if.sv ====
`default_nettype none

interface i2c_cmd_if;
    import eeprom_pkg::*;

    logic                 go;
    i2c_op_t              op;
    logic [3:0]           dev;
    logic [addr_bits-1:0] addr;
    logic [7:0]           wdata;
    logic                 busy;
    logic                 done;
    logic                 ack_err;
    logic [7:0]           rdata;

    modport regs (
        output go, op, dev, addr, wdata,
        input  busy, done, ack_err, rdata
    );

    modport engine (
        input  go, op, dev, addr, wdata,
        output busy, done, ack_err, rdata
    );

endinterface

`default_nettype wire

// ==== verilog/apb_i2c_regs.sv ====
`default_nettype none

module apb_i2c_regs (
    input  logic        sda,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    i2c_cmd_if.regs     cmd
);
    import eeprom_pkg::*;

    logic                 access;
    logic                 mapped;
    logic                 busy_any;
    logic                 ctrl_wr;
    logic                 start_op;
    logic                 go_q;
    i2c_op_t              op_q;
    logic [3:0]           dev_q;
    logic [addr_bits-1:0] addr_q;
    logic [7:0]           wdata_q;
    logic [7:0]           rdata_q;
    logic                 done_q;
    logic                 err_q;

    assign access   = psel & penable;
    assign mapped   = paddr inside {reg_ctrl, reg_addr, reg_wdata, reg_status, reg_rdata};
    // Busy covers the go cycle before the engine answers and the done cycle before capture
    assign busy_any = cmd.busy | go_q | cmd.done;
    assign ctrl_wr  = access & pwrite & (paddr == reg_ctrl);
    assign start_op = ctrl_wr & pwdata[0] & ~busy_any;
    assign pslverr  = access & (~mapped | (ctrl_wr & pwdata[0] & busy_any));

    assign cmd.go    = go_q;
    assign cmd.op    = op_q;
    assign cmd.dev   = dev_q;
    assign cmd.addr  = addr_q;
    assign cmd.wdata = wdata_q;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            go_q    <= 1'b0;
            op_q    <= op_write;
            dev_q   <= 4'h0;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
            rdata_q <= 8'h00;
        end
        else
        begin
            go_q <= start_op;
            if (start_op)
            begin
                op_q   <= i2c_op_t'(pwdata[1]);
                dev_q  <= pwdata[7:4];
                done_q <= 1'b0;
                err_q  <= 1'b0;
            end
            else if (cmd.done)
            begin
                done_q  <= 1'b1;
                err_q   <= cmd.ack_err;
                rdata_q <= cmd.rdata;
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (access && pwrite && paddr == reg_addr)
        begin
            addr_q <= pwdata[addr_bits-1:0];
        end
        if (access && pwrite && paddr == reg_wdata)
        begin
            wdata_q <= pwdata[7:0];
        end
    end

    always_comb
    begin
        case (paddr)
            reg_ctrl:   prdata = {24'd0, dev_q, 2'b00, op_q, 1'b0};
            reg_addr:   prdata = {21'd0, addr_q};
            reg_wdata:  prdata = {24'd0, wdata_q};
            reg_status: prdata = {29'd0, err_q, done_q, busy_any};
            reg_rdata:  prdata = {24'd0, rdata_q};
            default:    prdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/i2c_bit_engine.sv ====
`default_nettype none

module i2c_bit_engine (
    input  logic      sda,
    input  logic      rst,
    i2c_cmd_if.engine cmd,
    output logic      scl,
    output logic      data_low,
    input  logic      data_in
);
    import eeprom_pkg::*;

    eng_state_t                    state;
    logic [$clog2(2*scl_half)-1:0] cnt;
    logic                          bit_end;
    logic [2:0]                    bitn;
    logic [1:0]                    phase;
    logic [7:0]                    shreg;
    i2c_op_t                       op_q;
    logic [3:0]                    dev_q;
    logic [addr_bits-1:0]          addr_q;
    logic [7:0]                    wdata_q;

    // Each bit is one low half of scl followed by one high half
    assign bit_end = (cnt == 2 * scl_half - 1);
    assign scl     = (state == e_idle || state == e_start) ? 1'b1 : (cnt >= scl_half);

    always_ff @(posedge sda)
    begin
        if (state == e_idle && cmd.go)
        begin
            op_q    <= cmd.op;
            dev_q   <= cmd.dev;
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
        end
    end

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state       <= e_idle;
            cnt         <= '0;
            bitn        <= 3'd0;
            phase       <= 2'd0;
            data_low    <= 1'b0;
            cmd.busy    <= 1'b0;
            cmd.done    <= 1'b0;
            cmd.ack_err <= 1'b0;
            cmd.rdata   <= 8'h00;
        end
        else
        begin
            cmd.done <= 1'b0;

            // Data moves one clock into the low half, start and stop edges mid-high
            if (cnt == 0)
            begin
                case (state)
                    e_send_byte: data_low <= ~shreg[7];
                    e_stop:      data_low <= 1'b1;
                    default:     data_low <= 1'b0;
                endcase
            end
            else if (cnt == scl_half + scl_half / 2 - 1)
            begin
                if (state == e_start || state == e_restart)
                begin
                    data_low <= 1'b1;
                end
                else if (state == e_stop)
                begin
                    data_low <= 1'b0;
                end
            end

            if (state == e_idle)
            begin
                cnt <= '0;
                if (cmd.go)
                begin
                    state       <= e_start;
                    phase       <= 2'd0;
                    cmd.busy    <= 1'b1;
                    cmd.ack_err <= 1'b0;
                    cmd.rdata   <= 8'h00;
                end
            end
            else
            begin
                cnt <= bit_end ? '0 : cnt + 1'b1;
                if (bit_end)
                begin
                    case (state)
                        e_start:
                        begin
                            shreg <= {dev_q, addr_q[addr_bits-1:8], 1'b0};
                            state <= e_send_byte;
                        end
                        e_send_byte:
                        begin
                            shreg <= {shreg[6:0], 1'b0};
                            bitn  <= bitn + 3'd1;
                            if (bitn == 3'd7)
                            begin
                                state <= e_get_ack;
                            end
                        end
                        e_get_ack:
                        begin
                            if (data_in)
                            begin
                                cmd.ack_err <= 1'b1;
                                state       <= e_stop;
                            end
                            else if (phase == 2'd0)
                            begin
                                shreg <= addr_q[7:0];
                                phase <= 2'd1;
                                state <= e_send_byte;
                            end
                            else if (phase == 2'd1)
                            begin
                                if (op_q == op_write)
                                begin
                                    shreg <= wdata_q;
                                    phase <= 2'd2;
                                    state <= e_send_byte;
                                end
                                else
                                begin
                                    state <= e_restart;
                                end
                            end
                            else if (phase == 2'd2)
                            begin
                                state <= e_stop;
                            end
                            else
                            begin
                                state <= e_recv_byte;
                            end
                        end
                        e_restart:
                        begin
                            shreg <= {dev_q, addr_q[addr_bits-1:8], 1'b1};
                            phase <= 2'd3;
                            state <= e_send_byte;
                        end
                        e_recv_byte:
                        begin
                            shreg <= {shreg[6:0], data_in};
                            bitn  <= bitn + 3'd1;
                            if (bitn == 3'd7)
                            begin
                                state <= e_send_nack;
                            end
                        end
                        e_send_nack:
                        begin
                            cmd.rdata <= shreg;
                            state     <= e_stop;
                        end
                        default:
                        begin
                            state    <= e_idle;
                            cmd.busy <= 1'b0;
                            cmd.done <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eeprom_2k_slave.sv ====
`default_nettype none

module eeprom_2k_slave (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic data_in,
    output logic data_low
);
    import eeprom_pkg::*;

    slv_state_t           state;
    slv_state_t           next_q;
    logic                 scl_q;
    logic                 scl_p;
    logic                 dat_q;
    logic                 dat_p;
    logic                 start_det;
    logic                 stop_det;
    logic                 scl_rise;
    logic                 scl_fall;
    logic                 byte_done;
    logic                 mem_we;
    logic [2:0]           bitn;
    logic [7:0]           shreg;
    logic [7:0]           byte_in;
    logic [2:0]           blk_q;
    logic [7:0]           addr_q;
    logic [7:0]           rbuf;
    logic [addr_bits-1:0] wr_addr;
    logic [addr_bits-1:0] rd_addr;
    logic [7:0]           mem [mem_depth] = '{default: 8'h00};

    assign start_det = scl_q & scl_p & dat_p & ~dat_q;
    assign stop_det  = scl_q & scl_p & ~dat_p & dat_q;
    assign scl_rise  = scl_q & ~scl_p;
    assign scl_fall  = ~scl_q & scl_p;
    assign byte_in   = {shreg[6:0], dat_q};
    assign byte_done = scl_rise & (bitn == 3'd7);
    // Control bits 3:1 select one of the eight 256-byte blocks
    assign wr_addr   = {blk_q, addr_q};
    assign rd_addr   = {byte_in[3:1], addr_q};
    assign mem_we    = ~rst & (state == s_wdata) & byte_done;

    always_ff @(posedge sda)
    begin
        if (mem_we)
        begin
            mem[wr_addr] <= byte_in;
        end
    end

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state    <= s_idle;
            next_q   <= s_idle;
            scl_q    <= 1'b1;
            scl_p    <= 1'b1;
            dat_q    <= 1'b1;
            dat_p    <= 1'b1;
            bitn     <= 3'd0;
            data_low <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            scl_p <= scl_q;
            dat_q <= data_in;
            dat_p <= dat_q;

            if (start_det)
            begin
                state    <= s_ctrl;
                bitn     <= 3'd0;
                data_low <= 1'b0;
            end
            else if (stop_det)
            begin
                state    <= s_idle;
                data_low <= 1'b0;
            end
            else
            begin
                if (scl_rise && (state == s_ctrl || state == s_addr || state == s_wdata))
                begin
                    shreg <= byte_in;
                    bitn  <= bitn + 3'd1;
                end

                case (state)
                    s_ctrl:
                    begin
                        if (byte_done && byte_in[7:4] == dev_type)
                        begin
                            blk_q  <= byte_in[3:1];
                            rbuf   <= mem[rd_addr];
                            state  <= s_ack;
                            next_q <= byte_in[0] ? s_rdata : s_addr;
                        end
                        else if (byte_done)
                        begin
                            state <= s_ignore;
                        end
                    end
                    s_addr:
                    begin
                        if (byte_done)
                        begin
                            addr_q <= byte_in;
                            state  <= s_ack;
                            next_q <= s_wdata;
                        end
                    end
                    s_wdata:
                    begin
                        if (byte_done)
                        begin
                            state  <= s_ack;
                            next_q <= s_idle;
                        end
                    end
                    s_ack:
                    begin
                        // First fall pulls the line low, the second ends the ack bit
                        if (scl_fall && !data_low)
                        begin
                            data_low <= 1'b1;
                        end
                        else if (scl_fall)
                        begin
                            state    <= next_q;
                            data_low <= (next_q == s_rdata) & ~rbuf[7];
                        end
                    end
                    s_rdata:
                    begin
                        if (scl_fall)
                        begin
                            bitn <= bitn + 3'd1;
                            rbuf <= {rbuf[6:0], 1'b0};
                            if (bitn == 3'd7)
                            begin
                                data_low <= 1'b0;
                                state    <= s_idle;
                            end
                            else
                            begin
                                data_low <= ~rbuf[6];
                            end
                        end
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/i2c_eeprom_top.sv ====
`default_nettype none

module i2c_eeprom_top (
    input  logic        sda,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        scl,
    output logic        i2c_data
);

    logic eng_low;
    logic slv_low;

    i2c_cmd_if cmd_if ();

    apb_i2c_regs apb_i2c_regs_inst (
        .sda     (sda),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .cmd     (cmd_if.regs)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .sda      (sda),
        .rst      (rst),
        .cmd      (cmd_if.engine),
        .scl      (scl),
        .data_low (eng_low),
        .data_in  (i2c_data)
    );

    eeprom_2k_slave eeprom_2k_slave_inst (
        .sda      (sda),
        .rst      (rst),
        .scl      (scl),
        .data_in  (i2c_data),
        .data_low (slv_low)
    );

    // Open-drain line, low when either side pulls
    assign i2c_data = ~(eng_low | slv_low);

endmodule

`default_nettype wire

// ==== verification/i2c_eeprom_chk.sv ====
`default_nettype none

module i2c_eeprom_chk (
    input logic                   sda,
    input logic                   rst,
    input logic                   scl,
    input logic                   data_in,
    input logic                   go,
    input logic                   busy,
    input logic                   done,
    input eeprom_pkg::eng_state_t state
);
    import eeprom_pkg::*;

    int err_data = 0;
    int err_flags = 0;
    int err_go = 0;

    // While scl stays high the data line may only move for a start or a stop
    assert property (@(posedge sda) disable iff (rst)
        (scl && $past(scl) && data_in != $past(data_in))
            |-> (state inside {e_start, e_restart, e_stop}))
    else
    begin
        $error("i2c_data changed while scl was high outside a start or stop");
        err_data = err_data + 1;
    end

    assert property (@(posedge sda) disable iff (rst) !(busy && done))
    else
    begin
        $error("busy and done were high in the same cycle");
        err_flags = err_flags + 1;
    end

    assert property (@(posedge sda) disable iff (rst) go |-> !busy)
    else
    begin
        $error("go was issued while the engine was busy");
        err_go = err_go + 1;
    end

endmodule

bind i2c_bit_engine i2c_eeprom_chk chk_inst (
    .sda     (sda),
    .rst     (rst),
    .scl     (scl),
    .data_in (data_in),
    .go      (cmd.go),
    .busy    (cmd.busy),
    .done    (cmd.done),
    .state   (state)
);

`default_nettype wire

// ==== verification/i2c_eeprom_tb.sv ====
`default_nettype none

module i2c_eeprom_tb;
    import eeprom_pkg::*;

    localparam int half_period = 20;
    localparam int poll_limit  = 400;
    localparam int num_random  = 12;

    logic        sda;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        scl;
    logic        i2c_data;

    // Record layout: op[39:36] dev[35:32] addr[31:20] wdata[19:12] err[11:8] rdata[7:0]
    logic [39:0] stim [64];
    logic [7:0]  model [mem_depth];
    logic [10:0] rand_addr [num_random];
    logic [31:0] rd_val;
    logic [31:0] rnd;
    logic        err_bit;
    int          rec;
    int          chk_errors;

    i2c_eeprom_top i2c_eeprom_top_inst (
        .sda      (sda),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .scl      (scl),
        .i2c_data (i2c_data)
    );

    always #(half_period) sda = ~sda;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge sda);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge sda);
        penable = 1'b1;
        // Sample in the middle of the access cycle
        #(half_period / 2);
        err = pslverr;
        @(negedge sda);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge sda);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge sda);
        penable = 1'b1;
        #(half_period / 2);
        data = prdata;
        err  = pslverr;
        @(negedge sda);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle(output logic [31:0] status);
        int   polls;
        logic err;
        polls  = 0;
        status = 32'd1;
        while (status[0] && polls < poll_limit)
        begin
            apb_read(reg_status, status, err);
            polls++;
        end
        if (status[0])
        begin
            $display("Timeout: the operation was still busy after %0d status polls", poll_limit);
            $display("CHECKS FAILED");
            $fatal(1, "Operation did not finish");
        end
    endtask

    task automatic run_op(input string name, input logic op, input logic [3:0] dev,
                          input logic [10:0] addr, input logic [7:0] wdata,
                          input logic exp_err, input logic [7:0] exp_rdata);
        logic [31:0] status;
        logic [31:0] rdata;
        logic        err;
        apb_write(reg_addr, {21'd0, addr}, err);
        apb_write(reg_wdata, {24'd0, wdata}, err);
        apb_write(reg_ctrl, {24'd0, dev, 2'b00, op, 1'b1}, err);
        check_value({name, " go pslverr"}, 32'd0, {31'd0, err});
        wait_idle(status);
        // Status holds ack_err, done, busy from bit 2 down
        check_value({name, " status"}, {29'd0, exp_err, 2'b10}, status);
        if (op && !exp_err)
        begin
            apb_read(reg_rdata, rdata, err);
            check_value({name, " rdata"}, {24'd0, exp_rdata}, rdata);
        end
    endtask

    initial
    begin
        rnd     = $urandom(44695);
        sda     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 5'd0;
        pwdata  = 32'd0;
        foreach (model[i])
            model[i] = 8'h00;
        foreach (stim[i])
            stim[i] = '1;
        $readmemh("verification/eeprom_stim.txt", stim);
        repeat (8) @(negedge sda);
        rst = 1'b0;

        apb_read(reg_status, rd_val, err_bit);
        check_value("reset status", 32'd0, rd_val);
        check_value("reset status pslverr", 32'd0, {31'd0, err_bit});
        check_value("reset scl", 32'd1, {31'd0, scl});
        check_value("reset i2c_data", 32'd1, {31'd0, i2c_data});

        rec = 0;
        while (rec < 64 && stim[rec][39:36] != 4'hF)
        begin
            run_op($sformatf("record %0d", rec), stim[rec][36], stim[rec][35:32],
                   stim[rec][30:20], stim[rec][19:12], stim[rec][8], stim[rec][7:0]);
            if (!stim[rec][36] && !stim[rec][8])
                model[stim[rec][30:20]] = stim[rec][19:12];
            rec++;
        end

        // A second go and an unmapped read while a write is running
        apb_write(reg_addr, 32'h600, err_bit);
        apb_write(reg_wdata, 32'h99, err_bit);
        apb_write(reg_ctrl, {24'd0, dev_type, 4'b0001}, err_bit);
        check_value("first go pslverr", 32'd0, {31'd0, err_bit});
        apb_write(reg_ctrl, {24'd0, dev_type, 4'b0011}, err_bit);
        check_value("go while busy pslverr", 32'd1, {31'd0, err_bit});
        apb_read(5'h14, rd_val, err_bit);
        check_value("unmapped read pslverr", 32'd1, {31'd0, err_bit});
        wait_idle(rd_val);
        check_value("busy write status", 32'h2, rd_val);
        model[11'h600] = 8'h99;
        run_op("busy write readback", 1'b1, dev_type, 11'h600, 8'h00, 1'b0, 8'h99);

        for (int i = 0; i < num_random; i++)
        begin
            rnd = $urandom;
            rand_addr[i] = rnd[10:0];
            model[rnd[10:0]] = rnd[23:16];
            run_op($sformatf("random write %0d", i), 1'b0, dev_type, rnd[10:0], rnd[23:16],
                   1'b0, 8'h00);
        end
        for (int i = 0; i < num_random; i++)
        begin
            run_op($sformatf("random read %0d", i), 1'b1, dev_type, rand_addr[i], 8'h00,
                   1'b0, model[rand_addr[i]]);
        end

        chk_errors = i2c_eeprom_top_inst.i2c_bit_engine_inst.chk_inst.err_data
                   + i2c_eeprom_top_inst.i2c_bit_engine_inst.chk_inst.err_flags
                   + i2c_eeprom_top_inst.i2c_bit_engine_inst.chk_inst.err_go;
        if (chk_errors != 0)
        begin
            $display("Bus assertions failed %0d times during the run", chk_errors);
            $display("CHECKS FAILED");
            $fatal(1, "Assertion failures");
        end
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/eeprom_stim.txt ====
// Columns: op_dev_addr_wdata_err_rdata in hex; op 0 is a write and 1 a read
// err 1 expects a missing acknowledge, rdata is the expected byte of a read
0_a_000_11_0_00
1_a_000_00_0_11
0_a_1f0_22_0_00
1_a_1f0_00_0_22
0_a_2a5_33_0_00
0_a_6a5_44_0_00
1_a_2a5_00_0_33
1_a_6a5_00_0_44
0_a_3c7_55_0_00
1_a_3c7_00_0_55
0_a_40e_66_0_00
1_a_40e_00_0_66
0_a_57d_77_0_00
1_a_57d_00_0_77
0_a_7ff_88_0_00
1_a_7ff_00_0_88
1_a_4c3_00_0_00
0_b_000_ee_1_00
1_5_000_00_1_00
1_a_000_00_0_11

// ==== tb.f ====
verilog/eeprom_pkg.sv
verilog/i2c_cmd_if.sv
verilog/apb_i2c_regs.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_2k_slave.sv
verilog/i2c_eeprom_top.sv
verification/i2c_eeprom_chk.sv
verification/i2c_eeprom_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module i2c_eeprom_tb -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vi2c_eeprom_tb +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
